//--- files.f
+incdir+hw
+incdir+sim
hw/mini_accel_pkg.sv
hw/axil_reg_slave.sv
hw/booth_mul_int8.sv
hw/mac_accumulator.sv
hw/mini_accel_top.sv
sim/tb_mini_accel.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert \
    -f files.f \
    --top-module tb_mini_accel \
    -Mdir obj_dir \
    -o tb_mini_accel

if ./obj_dir/tb_mini_accel > "$LOG" 2>&1; then
    sim_status=0
else
    sim_status=1
fi
cat "$LOG"

if [ "$sim_status" -ne 0 ] || grep -qF '** FAIL **' "$LOG"; then
    echo "simulation failed, see $LOG"
    exit 1
fi
echo "simulation passed"

//--- sim/tb_axil_bfm.svh
`ifndef TB_AXIL_BFM_SVH
`define TB_AXIL_BFM_SVH

// hold bready or rready off for 0 to 3 cycles
task automatic hold_ready();
    int n;
    n = $random(seed) & 3;
    repeat (n) begin
        @(posedge clock);
        #DRIVE_DLY;
    end
endtask

// single write entered and left just after a rising edge
task automatic axil_write(input axil_addr_t addr, input axil_data_t data,
                          output axil_resp_t resp);
    awaddr  = addr;
    wdata   = data;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    @(negedge clock);
    while (!awready && !wready) begin
        @(negedge clock);
    end
    // address and data are taken in the same cycle
    if (awready !== wready) begin
        $display("error at %0t: awready and wready did not rise together", $time);
        fail_count++;
    end
    @(posedge clock);
    #DRIVE_DLY;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    hold_ready();
    bready = 1'b1;
    @(negedge clock);
    while (!bvalid) begin
        @(negedge clock);
    end
    resp = bresp;
    @(posedge clock);
    #DRIVE_DLY;
    bready = 1'b0;
endtask

// single read with the same timing as the write
task automatic axil_read(input axil_addr_t addr, output axil_data_t data,
                         output axil_resp_t resp);
    araddr  = addr;
    arvalid = 1'b1;
    @(negedge clock);
    while (!arready) begin
        @(negedge clock);
    end
    @(posedge clock);
    #DRIVE_DLY;
    arvalid = 1'b0;
    hold_ready();
    rready = 1'b1;
    @(negedge clock);
    while (!rvalid) begin
        @(negedge clock);
    end
    data = rdata;
    resp = rresp;
    @(posedge clock);
    #DRIVE_DLY;
    rready = 1'b0;
endtask

`endif

//--- sim/tb_mini_accel.sv
`default_nettype none

`include "accel_config.svh"

module tb_mini_accel;
    import mini_accel_pkg::*;

    localparam int DRIVE_DLY = 10;
    localparam int N_RANDOM  = 120;
    localparam int N_ACC     = 60;
    localparam int N_HOLD    = 5;
    localparam int MAX_POLLS = 20;
    // a product is a write, a couple of polls and two read-backs, at most 40 cycles each
    localparam int N_OPS          = 4 * (N_RANDOM + 4 + N_ACC + N_HOLD + 3) + 12;
    localparam int TIMEOUT_CYCLES = N_OPS * 40;

    logic       clock;
    logic       arst_n;
    axil_addr_t awaddr;
    logic       awvalid;
    logic       awready;
    axil_data_t wdata;
    logic       wvalid;
    logic       wready;
    axil_resp_t bresp;
    logic       bvalid;
    logic       bready;
    axil_addr_t araddr;
    logic       arvalid;
    logic       arready;
    axil_data_t rdata;
    axil_resp_t rresp;
    logic       rvalid;
    logic       rready;

    integer seed;
    int     pass_count;
    int     fail_count;
    int     cycle_count;

    // reference model
    acc_t  model_acc;
    logic  model_enable;
    prod_t model_prod;

    booth_state_e eng_state;
    assign eng_state = dut_i.booth_i.state;

    mini_accel_top dut_i (.*);

    `include "tb_axil_bfm.svh"

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    task automatic check_prod(input prod_t got, input prod_t exp, input string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s product %0d, expected %0d", $time, what, got, exp);
            fail_count++;
        end else begin
            pass_count++;
        end
    endtask

    task automatic check_acc(input acc_t got, input acc_t exp, input string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s acc %0d, expected %0d", $time, what, got, exp);
            fail_count++;
        end else begin
            pass_count++;
        end
    endtask

    task automatic check_resp(input axil_resp_t got, input axil_resp_t exp, input string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s resp %0d, expected %0d", $time, what, got, exp);
            fail_count++;
        end else begin
            pass_count++;
        end
    endtask

    task automatic check_word(input axil_data_t got, input axil_data_t exp, input string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s data %h, expected %h", $time, what, got, exp);
            fail_count++;
        end else begin
            pass_count++;
        end
    endtask

    function automatic prod_t ref_product(input int8_t a, input int8_t b);
        int full;
        full = int'(a) * int'(b);
        return prod_t'(full);
    endfunction

    task automatic start_product(input int8_t a, input int8_t b, input string what);
        axil_resp_t resp;
        model_prod = ref_product(a, b);
        axil_write(`REG_OPERANDS, {16'h0, b, a}, resp);
        check_resp(resp, RESP_OKAY, {what, " operand write"});
        if (model_enable) begin
            model_acc = model_acc + acc_t'(model_prod);
        end
    endtask

    // poll until done, reads before that must show busy only
    task automatic finish_product(input string what);
        axil_data_t data;
        axil_resp_t resp;
        int         polls;
        polls = 0;
        axil_read(`REG_STATUS, data, resp);
        while (data[1] !== 1'b1 && polls < MAX_POLLS) begin
            check_word(data, 32'h1, {what, " status while busy"});
            polls++;
            axil_read(`REG_STATUS, data, resp);
        end
        if (data[1] !== 1'b1) begin
            $display("error at %0t: %s never reported done", $time, what);
            fail_count++;
        end else begin
            check_word(data, 32'h2, {what, " status when done"});
        end
        axil_read(`REG_PRODUCT, data, resp);
        check_resp(resp, RESP_OKAY, {what, " product read"});
        check_prod(data[15:0], model_prod, what);
        check_word(data, axil_data_t'(acc_t'(model_prod)), {what, " product sign extension"});
        axil_read(`REG_ACC, data, resp);
        check_acc(data, model_acc, what);
    endtask

    task automatic end_test(input string name, input int fails_before);
        if (fail_count == fails_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, fail_count - fails_before);
        end
    endtask

    initial begin : watchdog
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("timeout: run still going after %0d cycles, booth engine in %s",
                 cycle_count, eng_state.name());
        $display("** FAIL **");
        $finish;
    end

    initial begin : main
        axil_data_t data;
        axil_resp_t resp;
        int         mark;
        int8_t      a;
        int8_t      b;
        seed         = 64002;
        pass_count   = 0;
        fail_count   = 0;
        model_acc    = '0;
        model_enable = 1'b0;
        model_prod   = '0;
        arst_n  = 1'b0;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        repeat (8) @(posedge clock);
        #DRIVE_DLY;
        arst_n = 1'b1;
        @(posedge clock);
        #DRIVE_DLY;

        mark = fail_count;
        axil_read(`REG_STATUS, data, resp);
        check_word(data, '0, "status after reset");
        check_resp(resp, RESP_OKAY, "status after reset");
        axil_read(`REG_PRODUCT, data, resp);
        check_prod(data[15:0], '0, "after reset");
        check_resp(resp, RESP_OKAY, "product after reset");
        axil_read(`REG_ACC, data, resp);
        check_acc(data, '0, "after reset");
        check_resp(resp, RESP_OKAY, "acc after reset");
        axil_read(5'h14, data, resp);
        check_word(data, '0, "unmapped read");
        check_resp(resp, RESP_SLVERR, "unmapped read");
        axil_write(5'h14, 32'hFFFF_FFFF, resp);
        check_resp(resp, RESP_SLVERR, "unmapped write");
        end_test("1 reset and unmapped", mark);

        mark = fail_count;
        for (int i = 0; i < N_RANDOM; i++) begin
            a = int8_t'($random(seed));
            b = int8_t'($random(seed));
            start_product(a, b, "random");
            finish_product("random");
        end
        start_product(int8_t'(-128), int8_t'(-128), "-128*-128");
        finish_product("-128*-128");
        start_product(int8_t'(-128), int8_t'(127), "-128*127");
        finish_product("-128*127");
        start_product(int8_t'(0), int8_t'($random(seed)), "0*x");
        finish_product("0*x");
        start_product(int8_t'(-1), int8_t'(-1), "-1*-1");
        finish_product("-1*-1");
        end_test("2 random products", mark);

        mark = fail_count;
        axil_write(`REG_CTRL, 32'h2, resp);
        check_resp(resp, RESP_OKAY, "enable write");
        model_enable = 1'b1;
        for (int i = 0; i < N_ACC; i++) begin
            start_product(int8_t'($random(seed)), int8_t'($random(seed)), "accumulate");
            finish_product("accumulate");
        end
        axil_write(`REG_CTRL, 32'h0, resp);
        check_resp(resp, RESP_OKAY, "disable write");
        model_enable = 1'b0;
        for (int i = 0; i < N_HOLD; i++) begin
            start_product(int8_t'($random(seed)), int8_t'($random(seed)), "acc held");
            finish_product("acc held");
        end
        end_test("3 accumulation", mark);

        mark = fail_count;
        axil_write(`REG_CTRL, 32'h3, resp);
        check_resp(resp, RESP_OKAY, "clear write");
        model_acc    = '0;
        model_enable = 1'b1;
        axil_read(`REG_ACC, data, resp);
        check_acc(data, '0, "after clear");
        start_product(int8_t'($random(seed)), int8_t'($random(seed)), "after clear");
        finish_product("after clear");
        end_test("4 clear", mark);

        mark = fail_count;
        a = int8_t'($random(seed));
        b = int8_t'($random(seed));
        start_product(a, b, "busy first");
        // second pair lands while the engine runs and must be dropped
        axil_write(`REG_OPERANDS, {16'h0, ~a, ~b}, resp);
        check_resp(resp, RESP_SLVERR, "write while busy");
        finish_product("busy first");
        end_test("5 busy rejection", mark);

        $display("checks passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- hw/mini_accel_top.sv
`default_nettype none

module mini_accel_top (
    input  logic                       clock,
    input  logic                       arst_n,
    input  mini_accel_pkg::axil_addr_t awaddr,
    input  logic                       awvalid,
    output logic                       awready,
    input  mini_accel_pkg::axil_data_t wdata,
    input  logic                       wvalid,
    output logic                       wready,
    output mini_accel_pkg::axil_resp_t bresp,
    output logic                       bvalid,
    input  logic                       bready,
    input  mini_accel_pkg::axil_addr_t araddr,
    input  logic                       arvalid,
    output logic                       arready,
    output mini_accel_pkg::axil_data_t rdata,
    output mini_accel_pkg::axil_resp_t rresp,
    output logic                       rvalid,
    input  logic                       rready
);
    import mini_accel_pkg::*;

    // front end to engine
    logic  start;
    int8_t multiplicand;
    int8_t multiplier;

    // engine to accumulator and status
    logic  busy;
    prod_t product;
    logic  prod_valid;

    // accumulator control and result
    logic  acc_clear;
    logic  acc_enable;
    acc_t  acc;
    logic  done;

    axil_reg_slave reg_slave_i (
        .clock        (clock),
        .arst_n       (arst_n),
        .awaddr       (awaddr),
        .awvalid      (awvalid),
        .awready      (awready),
        .wdata        (wdata),
        .wvalid       (wvalid),
        .wready       (wready),
        .bresp        (bresp),
        .bvalid       (bvalid),
        .bready       (bready),
        .araddr       (araddr),
        .arvalid      (arvalid),
        .arready      (arready),
        .rdata        (rdata),
        .rresp        (rresp),
        .rvalid       (rvalid),
        .rready       (rready),
        .busy         (busy),
        .product      (product),
        .acc          (acc),
        .done         (done),
        .start        (start),
        .multiplicand (multiplicand),
        .multiplier   (multiplier),
        .acc_clear    (acc_clear),
        .acc_enable   (acc_enable)
    );

    booth_mul_int8 booth_i (
        .clock        (clock),
        .arst_n       (arst_n),
        .start        (start),
        .multiplicand (multiplicand),
        .multiplier   (multiplier),
        .busy         (busy),
        .product      (product),
        .prod_valid   (prod_valid)
    );

    mac_accumulator mac_i (
        .clock      (clock),
        .arst_n     (arst_n),
        .prod_valid (prod_valid),
        .product    (product),
        .acc_clear  (acc_clear),
        .acc_enable (acc_enable),
        .start      (start),
        .acc        (acc),
        .done       (done)
    );

endmodule

`default_nettype wire

//--- hw/mac_accumulator.sv
`default_nettype none

`include "accel_config.svh"

module mac_accumulator (
    input  logic                  clock,
    input  logic                  arst_n,
    input  logic                  prod_valid,
    input  mini_accel_pkg::prod_t product,
    input  logic                  acc_clear,
    input  logic                  acc_enable,
    input  logic                  start,
    output mini_accel_pkg::acc_t  acc,
    output logic                  done
);
    import mini_accel_pkg::*;

    acc_t prod_ext;

    assign prod_ext = {{(`ACC_W-`PROD_W){product[`PROD_W-1]}}, product};

    // clear beats a product landing in the same cycle
    // sum wraps modulo 2^32
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            acc <= '0;
        end else if (acc_clear) begin
            acc <= '0;
        end else if (prod_valid && acc_enable) begin
            acc <= acc + prod_ext;
        end
    end

    // sticky done, re-armed by the next product
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            done <= 1'b0;
        end else if (start) begin
            done <= 1'b0;
        end else if (prod_valid) begin
            done <= 1'b1;
        end
    end

    // clear is a single-cycle command from the register front end
    assert property (@(posedge clock) disable iff (!arst_n) acc_clear |=> !acc_clear)
        else $error("mac_accumulator: acc_clear held for two cycles");

endmodule

`default_nettype wire

//--- hw/booth_mul_int8.sv
`default_nettype none

`include "accel_config.svh"

module booth_mul_int8 (
    input  logic                  clock,
    input  logic                  arst_n,
    input  logic                  start,
    input  mini_accel_pkg::int8_t multiplicand,
    input  mini_accel_pkg::int8_t multiplier,
    output logic                  busy,
    output mini_accel_pkg::prod_t product,
    output logic                  prod_valid
);
    import mini_accel_pkg::*;

    // {partial sum, multiplier, guard}
    // the extra partial sum bit keeps -128 in range
    localparam int SUM_W = `INT8_W + 1;
    localparam int REG_W = SUM_W + `INT8_W + 1;
    localparam int CNT_W = $clog2(`BOOTH_ITER + 1);

    booth_state_e     state;
    int8_t            mcand_q;
    logic [REG_W-1:0] booth_q;
    logic [REG_W-1:0] load_val;
    logic [CNT_W-1:0] iter_left;

    // one radix-2 step: add/sub the multiplicand, then arithmetic shift right
    function automatic logic [REG_W-1:0] booth_step(
        input logic [REG_W-1:0] r,
        input int8_t            m
    );
        logic signed [SUM_W-1:0] psum;
        logic signed [SUM_W-1:0] m_ext;
        logic signed [REG_W-1:0] full;
        psum  = r[REG_W-1 -: SUM_W];
        m_ext = {m[`INT8_W-1], m};
        case (r[1:0])
            2'b01:   psum = psum + m_ext;
            2'b10:   psum = psum - m_ext;
            default: ;
        endcase
        full = {psum, r[REG_W-SUM_W-1:0]};
        return full >>> 1;
    endfunction

    assign load_val = {{SUM_W{1'b0}}, multiplier, 1'b0};

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state     <= IDLE;
            booth_q   <= '0;
            iter_left <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        // first step folded into the load
                        booth_q   <= booth_step(load_val, multiplicand);
                        iter_left <= CNT_W'(`BOOTH_ITER - 1);
                        state     <= COMPUTE;
                    end
                end
                COMPUTE: begin
                    if (iter_left == '0) begin
                        state <= IDLE;
                    end else begin
                        booth_q   <= booth_step(booth_q, mcand_q);
                        iter_left <= iter_left - 1'b1;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (start) begin
            mcand_q <= multiplicand;
        end
    end

    assign busy       = (state == COMPUTE);
    assign prod_valid = (state == COMPUTE) && (iter_left == '0);
    // result sits just above the guard bit and holds while idle
    assign product    = booth_q[2*`INT8_W:1];

    // front end must hold off new operands until the engine is free
    assert property (@(posedge clock) disable iff (!arst_n) start |-> !busy)
        else $error("booth_mul_int8: start while busy");

    // fixed latency the front end and testbench rely on
    assert property (@(posedge clock) disable iff (!arst_n)
        start |-> ##(`BOOTH_ITER) prod_valid)
        else $error("booth_mul_int8: product not ready after BOOTH_ITER cycles");

endmodule

`default_nettype wire

//--- hw/axil_reg_slave.sv
`default_nettype none

`include "accel_config.svh"

module axil_reg_slave (
    input  logic                       clock,
    input  logic                       arst_n,
    input  mini_accel_pkg::axil_addr_t awaddr,
    input  logic                       awvalid,
    output logic                       awready,
    input  mini_accel_pkg::axil_data_t wdata,
    input  logic                       wvalid,
    output logic                       wready,
    output mini_accel_pkg::axil_resp_t bresp,
    output logic                       bvalid,
    input  logic                       bready,
    input  mini_accel_pkg::axil_addr_t araddr,
    input  logic                       arvalid,
    output logic                       arready,
    output mini_accel_pkg::axil_data_t rdata,
    output mini_accel_pkg::axil_resp_t rresp,
    output logic                       rvalid,
    input  logic                       rready,
    input  logic                       busy,
    input  mini_accel_pkg::prod_t      product,
    input  mini_accel_pkg::acc_t       acc,
    input  logic                       done,
    output logic                       start,
    output mini_accel_pkg::int8_t      multiplicand,
    output mini_accel_pkg::int8_t      multiplier,
    output logic                       acc_clear,
    output logic                       acc_enable
);
    import mini_accel_pkg::*;

    logic       wr_accept;
    logic       rd_accept;
    logic       op_reject;
    logic       wr_operands;
    axil_resp_t wr_resp;
    axil_data_t rd_data;
    axil_resp_t rd_resp;

    // one access of each kind in flight, a pending response blocks the next
    assign wr_accept = awvalid && wvalid && !bvalid;
    assign rd_accept = arvalid && !rvalid;

    assign awready = wr_accept;
    assign wready  = wr_accept;
    assign arready = rd_accept;

    // start is still in flight for one cycle before busy rises
    assign op_reject   = busy || start;
    assign wr_operands = wr_accept && (awaddr == `REG_OPERANDS) && !op_reject;

    always_comb begin : wr_decode
        wr_resp = RESP_OKAY;
        case (awaddr)
            `REG_OPERANDS: begin
                if (op_reject) begin
                    wr_resp = RESP_SLVERR;
                end
            end
            `REG_CTRL: begin
                wr_resp = RESP_OKAY;
            end
            default: begin
                wr_resp = RESP_SLVERR;
            end
        endcase
    end

    always_comb begin : rd_decode
        rd_data = '0;
        rd_resp = RESP_OKAY;
        case (araddr)
            `REG_OPERANDS, `REG_CTRL: begin
                // write-only, read back as zero
                rd_data = '0;
            end
            `REG_STATUS: begin
                rd_data = {{(`AXIL_DATA_W-2){1'b0}}, done, busy};
            end
            `REG_PRODUCT: begin
                rd_data = {{(`AXIL_DATA_W-`PROD_W){product[`PROD_W-1]}}, product};
            end
            `REG_ACC: begin
                rd_data = acc;
            end
            default: begin
                rd_resp = RESP_SLVERR;
            end
        endcase
    end

    // write channel and command pulses
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            bvalid     <= 1'b0;
            start      <= 1'b0;
            acc_clear  <= 1'b0;
            acc_enable <= 1'b0;
        end else begin
            start     <= wr_operands;
            acc_clear <= 1'b0;
            if (wr_accept) begin
                bvalid <= 1'b1;
                if (awaddr == `REG_CTRL) begin
                    acc_clear  <= wdata[0];
                    acc_enable <= wdata[1];
                end
            end else if (bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    // read channel
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            rvalid <= 1'b0;
        end else if (rd_accept) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    // operands and response payload
    always_ff @(posedge clock) begin
        if (wr_operands) begin
            multiplicand <= wdata[`INT8_W-1:0];
            multiplier   <= wdata[2*`INT8_W-1:`INT8_W];
        end
        if (wr_accept) begin
            bresp <= wr_resp;
        end
        if (rd_accept) begin
            rdata <= rd_data;
            rresp <= rd_resp;
        end
    end

    // responses wait for the master, unchanged
    assert property (@(posedge clock) disable iff (!arst_n)
        bvalid && !bready |=> bvalid && $stable(bresp))
        else $error("axil_reg_slave: write response dropped before bready");

    assert property (@(posedge clock) disable iff (!arst_n)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
        else $error("axil_reg_slave: read response changed before rready");

endmodule

`default_nettype wire

//--- hw/mini_accel_pkg.sv
`default_nettype none

`include "accel_config.svh"

package mini_accel_pkg;

    // signed operand, product and running sum
    typedef logic signed [`INT8_W-1:0] int8_t;
    typedef logic signed [`PROD_W-1:0] prod_t;
    typedef logic signed [`ACC_W-1:0]  acc_t;

    // axi4-lite fields
    typedef logic [`AXIL_ADDR_W-1:0] axil_addr_t;
    typedef logic [`AXIL_DATA_W-1:0] axil_data_t;
    typedef logic [1:0]              axil_resp_t;

    // response codes we actually return
    localparam axil_resp_t RESP_OKAY   = 2'b00;
    localparam axil_resp_t RESP_SLVERR = 2'b10;

    // booth engine fsm
    typedef enum logic {
        IDLE,
        COMPUTE
    } booth_state_e;

endpackage

`default_nettype wire

//--- hw/accel_config.svh
`ifndef ACCEL_CONFIG_SVH
`define ACCEL_CONFIG_SVH

// int8 data format
`define INT8_W      8
`define PROD_W      16
`define ACC_W       32

// axi4-lite bus
`define AXIL_ADDR_W 5
`define AXIL_DATA_W 32

// register map, byte offsets
`define REG_OPERANDS 5'h00
`define REG_CTRL     5'h04
`define REG_STATUS   5'h08
`define REG_PRODUCT  5'h0C
`define REG_ACC      5'h10

// one booth step per multiplier bit
`define BOOTH_ITER  8

`endif
